// ==== logic/prbs_align_pkg.sv ====
`default_nettype none

package prbs_align_pkg;

    // ====================
    // PRBS7 polynomial x^7 + x^6 + 1
    // ====================

    // Register length, first tap distance
    localparam int unsigned PRBS_ORDER = 7;
    // Second tap sits PRBS_ORDER - PRBS_TAP bits back
    localparam int unsigned PRBS_TAP = 1;

    // Generator fill pattern while disabled
    localparam logic [7:0] IDLE_BYTE = 8'hA5;

    // ====================
    // Alignment limits
    // ====================

    // Consecutive good words before lock
    localparam int unsigned LOCK_RUN = 16;
    // Flush cycles after each slip change
    localparam int unsigned SETTLE_CYCLES = 2;
    // Full offset passes before giving up
    localparam int unsigned MAX_SWEEPS = 2;

    // Saturating mismatch counter width
    localparam int unsigned ERR_W = 16;

    // Controller states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        SETTLE = 3'd1,
        SEEK   = 3'd2,
        LOCKED = 3'd3,
        FAIL   = 3'd4
    } align_state_t;

endpackage

`default_nettype wire

// ==== logic/align_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface align_if #(
    parameter int NBITS = 8
) ();

    // Slip offset into the two-word window
    logic [$clog2(NBITS)-1:0] slip_sel;
    // Checker flush while the offset settles
    logic                     chk_flush;
    // Error counting enable, high while locked
    logic                     count_en;
    // One strobe per compared word, with its verdict
    logic                     chk_valid;
    logic                     chk_match;

    modport ctrl (output slip_sel, chk_flush, count_en, input chk_valid, chk_match);

    modport slip (input slip_sel);

    modport check (input chk_flush, count_en, output chk_valid, chk_match);

endinterface

`default_nettype wire

// ==== logic/prbs_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_gen #(
    parameter int NBITS = 8
) (
    input  logic             clk_i,
    input  logic             resetn_i,
    input  logic             clear_i,
    input  logic             prbs_en_i,
    output logic [NBITS-1:0] prbs_word_o,
    output logic [NBITS-1:0] prbs_word_msb_o
);

    localparam int ORD  = prbs_align_pkg::PRBS_ORDER;
    localparam int TAP  = prbs_align_pkg::PRBS_TAP;
    localparam int REPS = (NBITS + 7) / 8;

    // Last ORD bits of the word on top, next word below
    logic [NBITS+ORD-1:0] ext;
    logic [REPS*8-1:0]    idle_rep;

    assign idle_rep = {REPS{prbs_align_pkg::IDLE_BYTE}};

    // MSB is the oldest bit, so fill downward
    always_comb begin
        ext = '0;
        ext[NBITS+ORD-1:NBITS] = prbs_word_o[ORD-1:0];
        for (int i = NBITS - 1; i >= 0; i--) begin
            ext[i] = ext[i+ORD] ^ ext[i+ORD-TAP];
        end
    end

    // Clear only acts while enabled; disabled sends the idle fill
    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            prbs_word_o <= '1;
        end else if (prbs_en_i) begin
            if (clear_i) begin
                prbs_word_o <= '1;
            end else begin
                prbs_word_o <= ext[NBITS-1:0];
            end
        end else begin
            prbs_word_o <= idle_rep[NBITS-1:0];
        end
    end

    // Mirror image for an MSB-first serializer
    always_comb begin
        for (int i = 0; i < NBITS; i++) begin
            prbs_word_msb_o[i] = prbs_word_o[NBITS-1-i];
        end
    end

endmodule

`default_nettype wire

// ==== logic/bit_slip.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_slip #(
    parameter int NBITS = 8
) (
    input  logic             clk_i,
    input  logic             resetn_i,
    input  logic [NBITS-1:0] rx_data_i,
    align_if.slip            ctl,
    output logic [NBITS-1:0] aligned_o
);

    localparam int SEL_W = $clog2(NBITS);
    localparam int SH_W  = SEL_W + 1;

    // ====================
    // Window select
    // ====================

    // Lane bits travel LSB first, so a word delayed by k bits
    // has its head in the previous word's upper k bits
    // and its tail in the current word's lower bits
    logic [NBITS-1:0]   prev_q;
    logic [2*NBITS-1:0] window;
    logic [SH_W-1:0]    shamt;
    logic [NBITS-1:0]   slice;

    assign window = {rx_data_i, prev_q};

    // Offset s picks window[2N-1-s -: N]
    // Offset 0 passes the current word, offset N-k undoes a k-bit delay
    assign shamt = SH_W'(NBITS) - {1'b0, ctl.slip_sel};
    assign slice = NBITS'(window >> shamt);

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            prev_q    <= '0;
            aligned_o <= '0;
        end else begin
            // Previous received word for the lower half
            prev_q    <= rx_data_i;
            // One cycle through the slip stage
            aligned_o <= slice;
        end
    end

endmodule

`default_nettype wire

// ==== logic/prbs_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_check #(
    parameter int NBITS = 8
) (
    input  logic                             clk_i,
    input  logic                             resetn_i,
    input  logic [NBITS-1:0]                 aligned_i,
    align_if.check                           ctl,
    output logic [prbs_align_pkg::ERR_W-1:0] err_count_o
);

    localparam int ORD = prbs_align_pkg::PRBS_ORDER;
    localparam int TAP = prbs_align_pkg::PRBS_TAP;

    logic [NBITS-1:0]     base_q;
    logic                 primed_q;
    logic                 cnt_en_q;
    logic [NBITS+ORD-1:0] ext;
    logic                 hit;

    // ====================
    // Prediction
    // ====================

    // Same recurrence as the generator, seeded by the last word seen
    always_comb begin
        ext = '0;
        ext[NBITS+ORD-1:NBITS] = base_q[ORD-1:0];
        for (int i = NBITS - 1; i >= 0; i--) begin
            ext[i] = ext[i+ORD] ^ ext[i+ORD-TAP];
        end
    end

    // All zeros is a stuck lane, never a match
    assign hit = (aligned_i == ext[NBITS-1:0]) && (aligned_i != '0);

    always_ff @(posedge clk_i) begin
        base_q <= aligned_i;
    end

    // ====================
    // Compare and count
    // ====================

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            primed_q      <= 1'b0;
            cnt_en_q      <= 1'b0;
            ctl.chk_valid <= 1'b0;
            ctl.chk_match <= 1'b0;
            err_count_o   <= '0;
        end else begin
            cnt_en_q <= ctl.count_en;
            // Base word after a flush is only captured, not compared
            if (ctl.chk_flush) begin
                primed_q      <= 1'b0;
                ctl.chk_valid <= 1'b0;
                ctl.chk_match <= 1'b0;
            end else begin
                primed_q      <= 1'b1;
                ctl.chk_valid <= primed_q;
                ctl.chk_match <= primed_q & hit;
            end
            // Fresh count on each new lock
            if (ctl.count_en && !cnt_en_q) begin
                err_count_o <= '0;
            end else if (ctl.count_en && ctl.chk_valid && !ctl.chk_match &&
                         err_count_o != '1) begin
                err_count_o <= err_count_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/align_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module align_ctrl #(
    parameter int NBITS = 8
) (
    input  logic                     clk_i,
    input  logic                     resetn_i,
    input  logic                     train_i,
    align_if.ctrl                    ctl,
    output logic                     lock_o,
    output logic                     align_fail_o,
    output logic [$clog2(NBITS)-1:0] slip_sel_o
);

    localparam int OFF_W = $clog2(NBITS);
    localparam int SET_W = $clog2(prbs_align_pkg::SETTLE_CYCLES + 1);
    localparam int RUN_W = $clog2(prbs_align_pkg::LOCK_RUN + 1);
    localparam int SWP_W = $clog2(prbs_align_pkg::MAX_SWEEPS + 1);

    prbs_align_pkg::align_state_t state_q;

    logic             train_q;
    logic [OFF_W-1:0] offset_q;
    logic [SET_W-1:0] settle_q;
    logic [RUN_W-1:0] run_q;
    logic [SWP_W-1:0] sweep_q;

    // ====================
    // Sweep FSM
    // ====================

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            state_q  <= prbs_align_pkg::IDLE;
            train_q  <= 1'b0;
            offset_q <= '0;
            settle_q <= '0;
            run_q    <= '0;
            sweep_q  <= '0;
        end else begin
            train_q <= train_i;
            // Dropping train aborts from any state
            if (!train_i) begin
                state_q <= prbs_align_pkg::IDLE;
            end else begin
                case (state_q)
                    prbs_align_pkg::IDLE: begin
                        if (!train_q) begin
                            state_q  <= prbs_align_pkg::SETTLE;
                            offset_q <= '0;
                            settle_q <= '0;
                            sweep_q  <= '0;
                        end
                    end
                    prbs_align_pkg::SETTLE: begin
                        if (settle_q == SET_W'(prbs_align_pkg::SETTLE_CYCLES - 1)) begin
                            state_q <= prbs_align_pkg::SEEK;
                            run_q   <= '0;
                        end else begin
                            settle_q <= settle_q + 1'b1;
                        end
                    end
                    prbs_align_pkg::SEEK: begin
                        if (ctl.chk_valid && ctl.chk_match) begin
                            run_q <= run_q + 1'b1;
                            if (run_q == RUN_W'(prbs_align_pkg::LOCK_RUN - 1)) begin
                                state_q <= prbs_align_pkg::LOCKED;
                            end
                        end else if (ctl.chk_valid) begin
                            // Bad word, try the next offset
                            settle_q <= '0;
                            run_q    <= '0;
                            state_q  <= prbs_align_pkg::SETTLE;
                            if (offset_q == OFF_W'(NBITS - 1)) begin
                                offset_q <= '0;
                                sweep_q  <= sweep_q + 1'b1;
                                if (sweep_q == SWP_W'(prbs_align_pkg::MAX_SWEEPS - 1)) begin
                                    state_q <= prbs_align_pkg::FAIL;
                                end
                            end else begin
                                offset_q <= offset_q + 1'b1;
                            end
                        end
                    end
                    // LOCKED and FAIL hold until train falls
                    default: begin
                    end
                endcase
            end
        end
    end

    // Status and datapath controls straight from state
    assign lock_o        = (state_q == prbs_align_pkg::LOCKED);
    assign align_fail_o  = (state_q == prbs_align_pkg::FAIL);
    assign ctl.chk_flush = (state_q == prbs_align_pkg::SETTLE);
    assign ctl.count_en  = (state_q == prbs_align_pkg::LOCKED);
    assign ctl.slip_sel  = offset_q;
    assign slip_sel_o    = offset_q;

endmodule

`default_nettype wire

// ==== logic/rx_align_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_align_top #(
    parameter int NBITS = 8
) (
    input  logic                             clk_i,
    input  logic                             resetn_i,
    input  logic                             train_i,
    input  logic                             clear_i,
    input  logic                             prbs_en_i,
    input  logic [NBITS-1:0]                 rx_data_i,
    output logic [NBITS-1:0]                 tx_word_o,
    output logic [NBITS-1:0]                 tx_word_msb_o,
    output logic                             lock_o,
    output logic                             align_fail_o,
    output logic [$clog2(NBITS)-1:0]         slip_sel_o,
    output logic [prbs_align_pkg::ERR_W-1:0] err_count_o
);

    // Controller to datapath control bundle
    align_if #(.NBITS(NBITS)) align_bus ();

    // Slip stage to checker
    logic [NBITS-1:0] aligned_word;

    // ====================
    // Transmit training word
    // ====================

    prbs_gen #(.NBITS(NBITS)) u_gen (
        .clk_i           (clk_i),
        .resetn_i        (resetn_i),
        .clear_i         (clear_i),
        .prbs_en_i       (prbs_en_i),
        .prbs_word_o     (tx_word_o),
        .prbs_word_msb_o (tx_word_msb_o)
    );

    // ====================
    // Receive alignment
    // ====================

    bit_slip #(.NBITS(NBITS)) u_slip (
        .clk_i     (clk_i),
        .resetn_i  (resetn_i),
        .rx_data_i (rx_data_i),
        .ctl       (align_bus),
        .aligned_o (aligned_word)
    );

    prbs_check #(.NBITS(NBITS)) u_check (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .aligned_i   (aligned_word),
        .ctl         (align_bus),
        .err_count_o (err_count_o)
    );

    align_ctrl #(.NBITS(NBITS)) u_ctrl (
        .clk_i        (clk_i),
        .resetn_i     (resetn_i),
        .train_i      (train_i),
        .ctl          (align_bus),
        .lock_o       (lock_o),
        .align_fail_o (align_fail_o),
        .slip_sel_o   (slip_sel_o)
    );

endmodule

`default_nettype wire

// ==== testbench/rx_align_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_align_sva #(
    parameter int NBITS = 8
) (
    input logic                             clk_i,
    input logic                             resetn_i,
    input logic                             train_i,
    input logic                             lock_i,
    input logic                             fail_i,
    input logic [$clog2(NBITS)-1:0]         slip_sel_i,
    input logic [prbs_align_pkg::ERR_W-1:0] err_count_i
);

    // Lock and fail are separate terminal states
    assert property (@(posedge clk_i) disable iff (!resetn_i) !(lock_i && fail_i))
        else $error("lock and fail status are high together");

    // Offset never leaves the window
    assert property (@(posedge clk_i) disable iff (!resetn_i) int'(slip_sel_i) < NBITS)
        else $error("slip offset outside the word");

    // Lock only ends when training stops
    assert property (@(posedge clk_i) disable iff (!resetn_i) lock_i && train_i |=> lock_i)
        else $error("lock dropped while training was still high");

    // Counter frozen unless locked
    assert property (@(posedge clk_i) disable iff (!resetn_i) !lock_i |=> $stable(err_count_i))
        else $error("error count moved without lock");

endmodule

bind rx_align_top rx_align_sva #(.NBITS(NBITS)) u_sva (
    .clk_i       (clk_i),
    .resetn_i    (resetn_i),
    .train_i     (train_i),
    .lock_i      (lock_o),
    .fail_i      (align_fail_o),
    .slip_sel_i  (slip_sel_o),
    .err_count_i (err_count_o)
);

`default_nettype wire

// ==== testbench/rx_align_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_align_tb;

    localparam int NBITS      = 8;
    localparam int SEL_W      = $clog2(NBITS);
    localparam int ERR_W      = prbs_align_pkg::ERR_W;
    localparam int ORD        = prbs_align_pkg::PRBS_ORDER;
    localparam int TAP        = prbs_align_pkg::PRBS_TAP;
    localparam int LOCK_BOUND = prbs_align_pkg::MAX_SWEEPS * NBITS *
                                (prbs_align_pkg::SETTLE_CYCLES + prbs_align_pkg::LOCK_RUN + 4);
    localparam int PRE        = 4;
    localparam int POST       = 4;
    localparam int SPACING    = 6;
    localparam int TAIL       = 8;
    localparam int NROWS      = 7;

    // One training run per row
    typedef struct packed {
        logic [7:0] k;
        logic [7:0] n_err;
        logic       clear;
        logic       en;
    } row_t;

    // Lane delay, injected errors, clear pulse, generator enable
    row_t rows [NROWS] = '{
        '{8'd0,  8'd3, 1'b1, 1'b1},
        '{8'd3,  8'd2, 1'b0, 1'b1},
        '{8'd5,  8'd4, 1'b0, 1'b1},
        '{8'd7,  8'd3, 1'b1, 1'b1},
        '{8'd11, 8'd2, 1'b0, 1'b1},
        '{8'd2,  8'd0, 1'b0, 1'b0},
        '{8'd8,  8'd2, 1'b0, 1'b1}
    };

    logic clk_i;
    logic resetn_i;
    logic train_i;
    logic clear_i;
    logic prbs_en_i;
    logic [NBITS-1:0] rx_data_i;
    logic [NBITS-1:0] tx_word_o;
    logic [NBITS-1:0] tx_word_msb_o;
    logic lock_o;
    logic align_fail_o;
    logic [SEL_W-1:0] slip_sel_o;
    logic [ERR_W-1:0] err_count_o;

    // Lane model and reference state
    logic [3*NBITS-1:0] hist;
    logic [NBITS-1:0]   prev_tx;
    logic [NBITS-1:0]   flip_mask;
    logic               prev_en;
    logic               prev_clear;
    logic               train_req;
    logic               clear_req;
    logic               en_req;
    logic [31:0]        lfsr;
    int                 delay_k;
    int                 cycles = 0;

    rx_align_top #(.NBITS(NBITS)) dut (
        .clk_i         (clk_i),
        .resetn_i      (resetn_i),
        .train_i       (train_i),
        .clear_i       (clear_i),
        .prbs_en_i     (prbs_en_i),
        .rx_data_i     (rx_data_i),
        .tx_word_o     (tx_word_o),
        .tx_word_msb_o (tx_word_msb_o),
        .lock_o        (lock_o),
        .align_fail_o  (align_fail_o),
        .slip_sel_o    (slip_sel_o),
        .err_count_o   (err_count_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ====================
    // Reference models
    // ====================

    // Serial x^7+x^6+1 with the oldest bit at the word MSB
    function automatic logic [NBITS-1:0] prbs_step(input logic [NBITS-1:0] w);
        logic [ORD-1:0]   h;
        logic [NBITS-1:0] nxt;
        logic             b;
        h = w[ORD-1:0];
        for (int i = NBITS - 1; i >= 0; i--) begin
            b = h[ORD-1] ^ h[ORD-1-TAP];
            nxt[i] = b;
            h = {h[ORD-2:0], b};
        end
        return nxt;
    endfunction

    function automatic logic [NBITS-1:0] next_tx_word(input logic [NBITS-1:0] w,
                                                      input logic en, input logic clr);
        logic [NBITS-1:0] idle;
        for (int i = 0; i < NBITS; i++) begin
            idle[i] = prbs_align_pkg::IDLE_BYTE[i % 8];
        end
        if (!en) begin
            return idle;
        end else if (clr) begin
            return '1;
        end
        return prbs_step(w);
    endfunction

    function automatic logic [NBITS-1:0] bit_reverse(input logic [NBITS-1:0] w);
        logic [NBITS-1:0] r;
        for (int i = 0; i < NBITS; i++) begin
            r[i] = w[NBITS-1-i];
        end
        return r;
    endfunction

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int timeout_limit();
        int total;
        total = 16;
        for (int r = 0; r < NROWS; r++) begin
            total += 1 + PRE + LOCK_BOUND + POST + int'(rows[r].n_err) * SPACING + TAIL;
        end
        return total;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Stopped at first error");
    endtask

    // One word time checked and driven at the falling edge
    task automatic run_cycle();
        logic [NBITS-1:0] expect_tx;
        @(negedge clk_i);
        expect_tx = next_tx_word(prev_tx, prev_en, prev_clear);
        assert (tx_word_o == expect_tx) else
            fail_now($sformatf("FAIL tx_word_o got %h expected %h", tx_word_o, expect_tx));
        assert (tx_word_msb_o == bit_reverse(tx_word_o)) else
            fail_now($sformatf("FAIL tx_word_msb_o got %h expected %h",
                               tx_word_msb_o, bit_reverse(tx_word_o)));
        // LSB-first lane delayed by k bits
        hist = {tx_word_o, hist[3*NBITS-1:NBITS]};
        rx_data_i = NBITS'(hist >> (2 * NBITS - delay_k)) ^ flip_mask;
        train_i    = train_req;
        clear_i    = clear_req;
        prbs_en_i  = en_req;
        prev_tx    = tx_word_o;
        prev_en    = en_req;
        prev_clear = clear_req;
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit()) begin
            $display("Timeout after %0d cycles before the table was done", cycles);
            $display("Finished with errors");
            $fatal(1, "Timeout");
        end
    end

    // ====================
    // Stimulus table
    // ====================

    initial begin
        logic [SEL_W-1:0] exp_sel;
        int               exp_err;
        int               pos;
        resetn_i  = 1'b0;
        train_i   = 1'b0;
        clear_i   = 1'b0;
        prbs_en_i = 1'b1;
        rx_data_i = '0;
        hist      = '0;
        flip_mask = '0;
        delay_k   = 0;
        lfsr      = 32'h20a5_cf23;
        train_req = 1'b0;
        clear_req = 1'b0;
        en_req    = 1'b1;
        repeat (2) @(negedge clk_i);
        resetn_i = 1'b1;
        assert (tx_word_o == {NBITS{1'b1}}) else
            fail_now($sformatf("FAIL tx_word_o got %h expected %h after reset",
                               tx_word_o, {NBITS{1'b1}}));
        prev_tx    = tx_word_o;
        prev_en    = 1'b1;
        prev_clear = 1'b0;

        for (int r = 0; r < NROWS; r++) begin
            delay_k   = int'(rows[r].k);
            en_req    = rows[r].en;
            train_req = 1'b0;
            clear_req = rows[r].clear;
            run_cycle();
            clear_req = 1'b0;
            repeat (PRE) run_cycle();
            train_req = 1'b1;
            while (!lock_o && !align_fail_o) begin
                run_cycle();
            end
            if (rows[r].en) begin
                assert (lock_o && !align_fail_o) else
                    fail_now($sformatf("Alignment gave up for a %0d-bit lane delay", delay_k));
                exp_sel = SEL_W'((NBITS - delay_k % NBITS) % NBITS);
                assert (slip_sel_o == exp_sel) else
                    fail_now($sformatf("FAIL slip_sel_o got %h expected %h", slip_sel_o, exp_sel));
                repeat (POST) run_cycle();
                assert (err_count_o == '0) else
                    fail_now($sformatf("FAIL err_count_o got %h expected %h", err_count_o, '0));
                exp_err = 0;
                for (int e = 0; e < int'(rows[r].n_err); e++) begin
                    pos = 0;
                    for (int b = 0; b < SEL_W; b++) begin
                        lfsr = lfsr_next(lfsr);
                        pos = pos | (int'(lfsr[0]) << b);
                    end
                    flip_mask = NBITS'(1) << pos;
                    run_cycle();
                    flip_mask = '0;
                    // Next prediction reads only the low PRBS_ORDER bits
                    if (((pos + 2 * NBITS - delay_k) % NBITS) < ORD) begin
                        exp_err += 2;
                    end else begin
                        exp_err += 1;
                    end
                    repeat (SPACING - 1) run_cycle();
                end
                repeat (TAIL) run_cycle();
                assert (err_count_o == ERR_W'(exp_err)) else
                    fail_now($sformatf("FAIL err_count_o got %h expected %h",
                                       err_count_o, ERR_W'(exp_err)));
            end else begin
                assert (align_fail_o && !lock_o) else
                    fail_now("Lock reported while the generator sent idle words");
            end
            train_req = 1'b0;
        end
        run_cycle();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/prbs_align_pkg.sv
logic/align_if.sv
logic/prbs_gen.sv
logic/bit_slip.sv
logic/prbs_check.sv
logic/align_ctrl.sv
logic/rx_align_top.sv
testbench/rx_align_sva.sv
testbench/rx_align_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module rx_align_tb \
    -f filelist.f \
    -o rx_align_sim

./obj_dir/rx_align_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
